/* Makefile */
SIM    = verilator
FLAGS  = --binary --timing --assert -Wno-fatal
TOP    = tb_posit_add
FLIST  = vlog.f
OBJDIR = obj_dir
LOG    = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* lead_one_count.sv */
// Leading-one search over the raw sum register
// Returns the distance of the top set bit from the MSB, all ones for zero
`timescale 1ns/1ps

module lead_one_count
    import posit_raw_pkg::*;
(
    input  logic [SUM_W-1:0]  value,
    output logic [LEAD_W-1:0] pos
);

    // Later hits overwrite earlier ones, so the highest set bit wins
    always_comb
    begin
        pos = '1;
        for (int i = 0; i < SUM_W; i++)
        begin
            if (value[i])
                pos = LEAD_W'(SUM_W - 1 - i);
        end
    end

endmodule

/* posit_add_sva.sv */
// Assertions on the done pulse of the posit adder
// Bound into the top level
`timescale 1ns/1ps

module posit_add_sva
    import posit_raw_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic done
);

    // Cycles from the edge sampling start to the edge raising done
    localparam int LATENCY = ADD_LATENCY + 2;

    reset_done_low: assert property (@(posedge clk)
        (!rst_n || !$past(rst_n)) |=> !done)
        else $error("done high during reset or in the cycle after");

    start_gives_done: assert property (@(posedge clk) disable iff (!rst_n)
        $past(start, LATENCY) |=> done)
        else $error("start not followed by done after the pipeline latency");

    done_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(start, LATENCY + 1))
        else $error("done without a matching start");

endmodule

bind posit_add_unit posit_add_sva sva_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .done  (done)
);

/* posit_add_unit.sv */
// Pipelined 16-bit posit adder, decode, raw add and encode
// Result and done arrive ten cycles after start
`timescale 1ns/1ps

module posit_add_unit
    import posit_fmt_pkg::*;
    import posit_raw_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  posit_t a,
    input  posit_t b,
    output posit_t result,
    output logic   done
);

    logic      a_sgn, a_nar, a_zero, a_valid;
    logic      b_sgn, b_nar, b_zero;
    scale_t    a_scale, b_scale;
    frac_t     a_frac, b_frac;
    logic      sum_sgn, sum_nar, sum_zero;
    scale_t    sum_scale;
    sum_frac_t sum_frac;
    logic      truncated;
    logic      done_raw;

    posit_decode dec_a (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .p     (a),
        .sgn   (a_sgn),
        .scale (a_scale),
        .frac  (a_frac),
        .nar   (a_nar),
        .zero  (a_zero),
        .valid (a_valid)
    );

    // Both decoders see the same start, only one valid is needed
    posit_decode dec_b (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .p     (b),
        .sgn   (b_sgn),
        .scale (b_scale),
        .frac  (b_frac),
        .nar   (b_nar),
        .zero  (b_zero),
        .valid ()
    );

    posit_raw_add add_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid     (a_valid),
        .a_sgn     (a_sgn),
        .a_scale   (a_scale),
        .a_frac    (a_frac),
        .a_nar     (a_nar),
        .a_zero    (a_zero),
        .b_sgn     (b_sgn),
        .b_scale   (b_scale),
        .b_frac    (b_frac),
        .b_nar     (b_nar),
        .b_zero    (b_zero),
        .sum_sgn   (sum_sgn),
        .sum_scale (sum_scale),
        .sum_frac  (sum_frac),
        .sum_nar   (sum_nar),
        .sum_zero  (sum_zero),
        .truncated (truncated),
        .done_raw  (done_raw)
    );

    posit_encode enc_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .done_raw  (done_raw),
        .sum_sgn   (sum_sgn),
        .sum_scale (sum_scale),
        .sum_frac  (sum_frac),
        .sum_nar   (sum_nar),
        .sum_zero  (sum_zero),
        .truncated (truncated),
        .result    (result),
        .done      (done)
    );

endmodule

/* posit_decode.sv */
// Posit decoder for one 16-bit es = 3 operand
// Captures the word on the start sample, then registers sign, scale, fraction and flags
`timescale 1ns/1ps

module posit_decode
    import posit_fmt_pkg::*;
    import posit_raw_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  posit_t p,
    output logic   sgn,
    output scale_t scale,
    output frac_t  frac,
    output logic   nar,
    output logic   zero,
    output logic   valid
);

    posit_t                p_q;
    logic                  start_q;
    posit_t                mag;
    logic [POSIT_W-2:0]    body;
    logic [POSIT_W-2:0]    rest;
    logic [4:0]            run;
    logic                  found;
    logic signed [5:0]     k;
    logic [POSIT_ES-1:0]   exp_bits;

    // Operand word as sampled together with start
    always_ff @(posedge clk)
    begin
        p_q <= p;
    end

    // Negative posits are two's complemented to get the magnitude
    assign mag  = p_q[POSIT_W-1] ? -p_q : p_q;
    assign body = mag[POSIT_W-2:0];

    // Length of the regime run starting below the sign bit
    always_comb
    begin
        run   = 5'(POSIT_W - 1);
        found = 1'b0;
        for (int i = POSIT_W - 3; i >= 0; i--)
        begin
            if (!found && body[i] != body[POSIT_W-2])
            begin
                run   = 5'(POSIT_W - 2 - i);
                found = 1'b1;
            end
        end
    end

    assign k = body[POSIT_W-2] ? 6'(run) - 6'd1 : -6'(run);

    // Drop regime and terminator so that missing exponent bits come in as zero
    assign rest     = body << (run + 5'd1);
    assign exp_bits = rest[POSIT_W-2 -: POSIT_ES];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            start_q <= 1'b0;
            valid   <= 1'b0;
        end
        else
        begin
            start_q <= start;
            valid   <= start_q;
        end
    end

    always_ff @(posedge clk)
    begin
        zero <= (p_q == POSIT_ZERO);
        nar  <= (p_q == POSIT_NAR);
        if (p_q == POSIT_ZERO || p_q == POSIT_NAR)
        begin
            sgn   <= 1'b0;
            scale <= '0;
            frac  <= '0;
        end
        else
        begin
            sgn   <= p_q[POSIT_W-1];
            scale <= {k, exp_bits};
            frac  <= rest[POSIT_W-2-POSIT_ES -: FRAC_W];
        end
    end

endmodule

/* posit_encode.sv */
// Posit encoder, packs the raw sum into a 16-bit es = 3 word
// with round to nearest even and saturation at maxpos and minpos
`timescale 1ns/1ps

module posit_encode
    import posit_fmt_pkg::*;
    import posit_raw_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      done_raw,
    input  logic      sum_sgn,
    input  scale_t    sum_scale,
    input  sum_frac_t sum_frac,
    input  logic      sum_nar,
    input  logic      sum_zero,
    input  logic      truncated,
    output posit_t    result,
    output logic      done
);

    localparam int MAX_SCALE = POSIT_MAX_K << POSIT_ES;
    localparam int PAD_W     = 2*POSIT_W - 2 - POSIT_ES - SUM_FRAC_W;

    logic                      neg_k;
    scale_t                    k;
    logic [3:0]                sh;
    logic signed [2*POSIT_W-1:0] pattern;
    logic signed [2*POSIT_W-1:0] shifted;
    logic [POSIT_W-2:0]        mag_trunc;
    logic [POSIT_W-2:0]        mag_round;
    logic                      guard;
    logic                      sticky;
    logic                      round_up;
    posit_t                    mag_word;
    posit_t                    signed_word;

    always_comb
    begin
        // Regime value and exponent from the scale
        neg_k = sum_scale < 0;
        k     = sum_scale >>> POSIT_ES;
        sh    = neg_k ? 4'(-k - scale_t'(1)) : 4'(k);

        // Arithmetic shift stretches the first regime bit into the run
        pattern = {~neg_k, neg_k, sum_scale[POSIT_ES-1:0], sum_frac, {PAD_W{1'b0}}};
        shifted = pattern >>> sh;

        mag_trunc = shifted[2*POSIT_W-1 -: POSIT_W-1];
        guard     = shifted[POSIT_W];
        sticky    = (|shifted[POSIT_W-1:0]) | truncated;
        round_up  = guard & (sticky | mag_trunc[0]);
        mag_round = mag_trunc + (POSIT_W-1)'(round_up);

        // Out of range magnitudes clamp, nothing rounds to zero or NaR
        if (sum_scale >= MAX_SCALE)
            mag_word = POSIT_MAXPOS;
        else if (sum_scale < -MAX_SCALE)
            mag_word = POSIT_MINPOS;
        else
            mag_word = {1'b0, mag_round};

        signed_word = sum_sgn ? -mag_word : mag_word;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            done <= 1'b0;
        else
            done <= done_raw;
    end

    always_ff @(posedge clk)
    begin
        if (sum_nar)
            result <= POSIT_NAR;
        else if (sum_zero)
            result <= POSIT_ZERO;
        else
            result <= signed_word;
    end

endmodule

/* posit_fmt_pkg.sv */
// Posit encoding constants for the 16-bit, es = 3 format
// and the encoded word type used at the ports
package posit_fmt_pkg;

    localparam int POSIT_W  = 16;
    localparam int POSIT_ES = 3;

    // Longest regime run that still fits in the word
    localparam int POSIT_MAX_K = POSIT_W - 2;

    typedef logic [POSIT_W-1:0] posit_t;

    // Fixed words
    localparam posit_t POSIT_ZERO   = '0;
    localparam posit_t POSIT_NAR    = {1'b1, {(POSIT_W-1){1'b0}}};
    localparam posit_t POSIT_MAXPOS = {1'b0, {(POSIT_W-1){1'b1}}};
    localparam posit_t POSIT_MINPOS = {{(POSIT_W-1){1'b0}}, 1'b1};

endpackage

/* posit_raw_add.sv */
// Raw-format posit adder, eight register stages from decoded operands
// to a normalized sum with a sticky truncation flag
`timescale 1ns/1ps

module posit_raw_add
    import posit_raw_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      valid,
    input  logic      a_sgn,
    input  scale_t    a_scale,
    input  frac_t     a_frac,
    input  logic      a_nar,
    input  logic      a_zero,
    input  logic      b_sgn,
    input  scale_t    b_scale,
    input  frac_t     b_frac,
    input  logic      b_nar,
    input  logic      b_zero,
    output logic      sum_sgn,
    output scale_t    sum_scale,
    output sum_frac_t sum_frac,
    output logic      sum_nar,
    output logic      sum_zero,
    output logic      truncated,
    output logic      done_raw
);

    logic [ADD_LATENCY-1:0] vld;

    logic                   a_ge_b;
    logic                   s1_hi_sgn, s1_lo_sgn, s1_lo_zero, s1_nar, s1_zero;
    scale_t                 s1_hi_scale, s1_lo_scale;
    frac_t                  s1_hi_frac, s1_lo_frac;
    logic [SCALE_W-1:0]     s1_diff;
    logic [SIG_W-1:0]       s1_lo_sig;
    logic [2*SIG_W-1:0]     s1_wide;
    logic                   s1_sticky;

    logic [SIG_W-1:0]       s2_hi_sig, s2_lo_sig;
    logic                   s2_sub, s2_trunc, s2_sgn, s2_nar, s2_zero;
    scale_t                 s2_scale;

    logic [SUM_W-1:0]       s3_sum, s4_sum, s5_sum, s6_sum, s7_norm;
    logic [LEAD_W-1:0]      s3_pos, s4_pos, s5_pos, s6_shamt;
    scale_t                 s3_scale, s4_scale, s5_scale, s6_scale, s7_scale;
    logic                   s3_trunc, s4_trunc, s5_trunc, s6_trunc, s7_trunc;
    logic                   s3_sgn, s4_sgn, s5_sgn, s6_sgn, s7_sgn;
    logic                   s3_nar, s4_nar, s5_nar, s6_nar, s7_nar;
    logic                   s3_zero, s4_zero, s5_zero, s6_zero, s7_zero;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            vld <= '0;
        else
            vld <= {vld[ADD_LATENCY-2:0], valid};
    end

    assign done_raw = vld[ADD_LATENCY-1];

    // Stage 1: larger magnitude goes to hi, a zero operand is always lo
    assign a_ge_b = b_zero | (~a_zero & ((a_scale > b_scale) |
                    ((a_scale == b_scale) & (a_frac >= b_frac))));

    always_ff @(posedge clk)
    begin
        s1_hi_sgn   <= a_ge_b ? a_sgn : b_sgn;
        s1_hi_scale <= a_ge_b ? a_scale : b_scale;
        s1_hi_frac  <= a_ge_b ? a_frac : b_frac;
        s1_lo_sgn   <= a_ge_b ? b_sgn : a_sgn;
        s1_lo_scale <= a_ge_b ? b_scale : a_scale;
        s1_lo_frac  <= a_ge_b ? b_frac : a_frac;
        s1_lo_zero  <= a_ge_b ? b_zero : a_zero;
        s1_nar      <= a_nar | b_nar;
        s1_zero     <= a_zero & b_zero;
    end

    // Stage 2: align lo, bits falling off the register feed the sticky flag
    assign s1_diff   = s1_hi_scale - s1_lo_scale;
    assign s1_lo_sig = {~s1_lo_zero, s1_lo_frac, 2'b00};
    assign s1_wide   = {s1_lo_sig, {SIG_W{1'b0}}} >> s1_diff;
    assign s1_sticky = (|s1_wide[SIG_W-1:0]) | ((s1_diff >= 2*SIG_W) & ~s1_lo_zero);

    always_ff @(posedge clk)
    begin
        s2_hi_sig <= {~s1_zero, s1_hi_frac, 2'b00};
        s2_lo_sig <= s1_wide[2*SIG_W-1:SIG_W];
        s2_trunc  <= s1_sticky;
        s2_sub    <= s1_hi_sgn ^ s1_lo_sgn;
        s2_sgn    <= s1_hi_sgn;
        s2_scale  <= s1_hi_scale;
        s2_nar    <= s1_nar;
        s2_zero   <= s1_zero;
    end

    // Stage 3: a truncated subtrahend takes one more LSB off, which keeps
    // the sum a floor of the exact value with the sticky as remainder
    always_ff @(posedge clk)
    begin
        if (s2_sub)
            s3_sum <= {1'b0, s2_hi_sig} - {1'b0, s2_lo_sig} - SUM_W'(s2_trunc);
        else
            s3_sum <= {1'b0, s2_hi_sig} + {1'b0, s2_lo_sig};
        s3_trunc <= s2_trunc;
        s3_sgn   <= s2_sgn;
        s3_scale <= s2_scale;
        s3_nar   <= s2_nar;
        s3_zero  <= s2_zero;
    end

    // Stage 4: leading-one position
    lead_one_count lead_i (
        .value (s3_sum),
        .pos   (s3_pos)
    );

    always_ff @(posedge clk)
    begin
        s4_sum   <= s3_sum;
        s4_pos   <= s3_pos;
        s4_trunc <= s3_trunc;
        s4_sgn   <= s3_sgn;
        s4_scale <= s3_scale;
        s4_nar   <= s3_nar;
        s4_zero  <= s3_zero;
    end

    // Stage 5: scale correction, hidden bit sits one below the carry
    always_ff @(posedge clk)
    begin
        if (s4_sum[SUM_W-1])
            s5_scale <= s4_scale + scale_t'(1);
        else
            s5_scale <= s4_scale - scale_t'(s4_pos - 4'd1);
        s5_sum   <= s4_sum;
        s5_pos   <= s4_pos;
        s5_trunc <= s4_trunc;
        s5_sgn   <= s4_sgn;
        s5_nar   <= s4_nar;
        s5_zero  <= s4_zero;
    end

    // Stage 6: shift amount, an all-zero sum is exact cancellation
    always_ff @(posedge clk)
    begin
        s6_shamt <= (s5_pos == '1) ? '0 : s5_pos;
        s6_zero  <= s5_zero | (s5_pos == '1);
        s6_sum   <= s5_sum;
        s6_scale <= s5_scale;
        s6_trunc <= s5_trunc;
        s6_sgn   <= s5_sgn;
        s6_nar   <= s5_nar;
    end

    // Stage 7: move the leading one up to the carry position
    always_ff @(posedge clk)
    begin
        s7_norm  <= s6_sum << s6_shamt;
        s7_scale <= s6_scale;
        s7_trunc <= s6_trunc;
        s7_sgn   <= s6_sgn;
        s7_nar   <= s6_nar;
        s7_zero  <= s6_zero;
    end

    // Stage 8: NaR overrides everything, zero is always positive
    always_ff @(posedge clk)
    begin
        sum_frac  <= s7_norm[SUM_FRAC_W-1:0];
        sum_scale <= s7_scale;
        sum_sgn   <= s7_sgn & ~s7_zero & ~s7_nar;
        sum_nar   <= s7_nar;
        sum_zero  <= s7_zero & ~s7_nar;
        truncated <= s7_trunc;
    end

endmodule

/* posit_raw_pkg.sv */
// Raw decoded posit value fields shared by decoder, adder and encoder
// Scale is regime * 8 + exponent, fractions carry no hidden bit
package posit_raw_pkg;

    localparam int SCALE_W    = 9;
    localparam int FRAC_W     = 10;
    // Sum fraction holds the fraction plus guard, round and a spare bit
    localparam int SUM_FRAC_W = FRAC_W + 3;
    // Aligned significand: hidden bit, fraction and two extra low bits
    localparam int SIG_W      = FRAC_W + 3;
    // Sum register including the carry bit
    localparam int SUM_W      = SIG_W + 1;
    localparam int LEAD_W     = 4;

    // Cycles from decoded operands to the raw sum
    localparam int ADD_LATENCY = 8;

    typedef logic signed [SCALE_W-1:0] scale_t;
    typedef logic [FRAC_W-1:0]         frac_t;
    typedef logic [SUM_FRAC_W-1:0]     sum_frac_t;

endpackage

/* tb_posit_add.sv */
// Testbench for the pipelined 16-bit posit adder
// Directed and random operand pairs checked against a reference model
`timescale 1ns/1ps

module tb_posit_add
    import posit_fmt_pkg::*;
    import posit_raw_pkg::*;
();

    localparam int LATENCY   = ADD_LATENCY + 2;
    localparam int MAX_SCALE = POSIT_MAX_K * 8;
    localparam int N_SPECIAL = 8;
    localparam int N_SAME    = 300;
    localparam int N_OPP     = 300;
    localparam int N_WIDE    = 200;
    localparam int N_BURST   = 100;
    localparam int N_GAPPED  = 100;
    localparam int MAX_GAP   = 3;
    localparam int N_STARTS  = N_SPECIAL + N_SAME + N_OPP + N_WIDE + N_BURST + N_GAPPED;
    // Reset, idle test, one cycle per start, gaps, drain per test, margin
    localparam int TIMEOUT   = 4 + 20 + N_STARTS + N_GAPPED * MAX_GAP
                               + 6 * (LATENCY + 2) + 100;

    logic   clk = 1'b0;
    logic   rst_n;
    logic   start;
    posit_t a;
    posit_t b;
    posit_t result;
    logic   done;

    posit_t x, y, exp_w, a_w, b_w;
    posit_t exp_q[$];
    posit_t a_q[$];
    posit_t b_q[$];
    int     edge_q[$];
    int     cycle = 0;
    int     stamp;
    int     errors = 0;
    int     checks = 0;
    int     test_errors = 0;
    int     test_checks = 0;

    posit_add_unit dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .a      (a),
        .b      (b),
        .result (result),
        .done   (done)
    );

    initial
    begin
        forever #5 clk = ~clk;
    end

    // Sign, scale and significand with the hidden bit at bit 12
    function automatic void split_posit(input posit_t w, output bit s, output int sc,
                                        output longint sig);
        posit_t m;
        int     i;
        int     run;
        int     e;
        bit     first;
        m     = w[POSIT_W-1] ? -w : w;
        s     = w[POSIT_W-1];
        first = m[POSIT_W-2];
        run   = 0;
        i     = POSIT_W - 2;
        while (i >= 0 && m[i] == first)
        begin
            run++;
            i--;
        end
        // Skip the regime terminator
        i--;
        e = 0;
        for (int j = 0; j < POSIT_ES; j++)
        begin
            e = 2 * e + ((i >= 0) ? int'(m[i]) : 0);
            i--;
        end
        sig = 1;
        for (int j = 0; j < 12; j++)
        begin
            sig = 2 * sig + ((i >= 0) ? longint'(m[i]) : 0);
            i--;
        end
        sc = (first ? run - 1 : -run) * 8 + e;
    endfunction

    function automatic posit_t add_ref(input posit_t p, input posit_t q);
        bit           sp, sq, sticky, guard, rest;
        int           cp, cq, diff, top, sc, k, e, pos;
        longint       gp, gq;
        logic [63:0]  f_hi, f_lo, f_sum;
        logic [127:0] bits;
        posit_t       mag;
        if (p == POSIT_NAR || q == POSIT_NAR)
            return POSIT_NAR;
        if (p == POSIT_ZERO)
            return q;
        if (q == POSIT_ZERO)
            return p;
        split_posit(p, sp, cp, gp);
        split_posit(q, sq, cq, gq);
        // Larger magnitude first
        if (cq > cp || (cq == cp && gq > gp))
            return add_ref(q, p);
        diff = cp - cq;
        // Hidden bit at bit 52 leaves 40 extra bits below the fraction
        f_hi = 64'(gp) << 40;
        if (diff >= 64)
        begin
            f_lo   = '0;
            sticky = 1'b1;
        end
        else
        begin
            f_lo   = (64'(gq) << 40) >> diff;
            sticky = (f_lo << diff) != (64'(gq) << 40);
        end
        // Lost subtrahend bits round the difference down, sticky holds the rest
        if (sp != sq)
            f_sum = f_hi - f_lo - 64'(sticky);
        else
            f_sum = f_hi + f_lo;
        if (f_sum == '0)
            return POSIT_ZERO;
        top = 63;
        while (!f_sum[top])
            top--;
        sc = cp + top - 52;
        if (sc >= MAX_SCALE)
            mag = POSIT_MAXPOS;
        else if (sc < -MAX_SCALE)
            mag = POSIT_MINPOS;
        else
        begin
            k    = sc >>> 3;
            e    = sc - 8 * k;
            bits = '0;
            pos  = 127;
            if (k >= 0)
            begin
                for (int j = 0; j <= k; j++)
                begin
                    bits[pos] = 1'b1;
                    pos--;
                end
                pos--;
            end
            else
            begin
                // Run of -k zeros, then the terminating one
                pos       = pos + k;
                bits[pos] = 1'b1;
                pos--;
            end
            for (int j = POSIT_ES - 1; j >= 0; j--)
            begin
                bits[pos] = e[j];
                pos--;
            end
            for (int j = top - 1; j >= 0; j--)
            begin
                bits[pos] = f_sum[j];
                pos--;
            end
            mag   = {1'b0, bits[127:113]};
            guard = bits[112];
            rest  = (|bits[111:0]) | sticky;
            if (guard && (rest || mag[0]))
                mag = mag + 1'b1;
        end
        return sp ? -mag : mag;
    endfunction

    task automatic issue(input posit_t p, input posit_t q);
        @(posedge clk);
        #1;
        start = 1'b1;
        a     = p;
        b     = q;
        exp_q.push_back(add_ref(p, q));
        a_q.push_back(p);
        b_q.push_back(q);
        // Start is sampled on the next edge
        edge_q.push_back(cycle + 1);
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
            start = 1'b0;
        end
    endtask

    task automatic close_test(input string name);
        idle(1);
        while (exp_q.size() != 0)
            idle(1);
        $display("%s: %0d checked, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT)
        begin
            $display("Run stopped after %0d cycles, results still missing", cycle);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Outputs are compared half a cycle after they change
    always @(negedge clk)
    begin
        if (!rst_n && done === 1'b1)
        begin
            $display("done is high during reset at %0t", $time);
            errors++;
        end
        else if (done === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                $display("done pulse at %0t with no start waiting for it", $time);
                errors++;
            end
            else
            begin
                exp_w = exp_q.pop_front();
                a_w   = a_q.pop_front();
                b_w   = b_q.pop_front();
                stamp = edge_q.pop_front();
                checks++;
                if (result !== exp_w)
                begin
                    $display("Error at %0t: %h + %h expected %h received %h",
                             $time, a_w, b_w, exp_w, result);
                    errors++;
                end
                if (cycle - stamp != LATENCY)
                begin
                    $display("Error at %0t: %h + %h done %0d cycles after start",
                             $time, a_w, b_w, cycle - stamp);
                    errors++;
                end
            end
        end
    end

    initial
    begin
        void'($urandom(32'h9471));
        rst_n = 1'b0;
        start = 1'b0;
        a     = '0;
        b     = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        idle(20);
        close_test("reset and idle");

        issue(16'h0000, 16'h0000);
        issue(16'h0000, 16'h4000);
        issue(16'hC000, 16'h0000);
        issue(POSIT_NAR, 16'h1234);
        issue(16'h3A00, POSIT_NAR);
        issue(16'h5123, -16'h5123);
        issue(16'hFFFF, 16'h0001);
        issue(POSIT_MAXPOS, POSIT_MAXPOS);
        close_test("special values");

        for (int n = 0; n < N_SAME; n++)
        begin
            x = posit_t'($urandom);
            if (n % 10 == 0)
                x = 16'h7F00 | posit_t'($urandom_range(255));
            // Odd pairs sit at nearly the same scale and tend to carry
            if (n % 2 == 1)
                y = x ^ posit_t'($urandom_range(255));
            else
                y = posit_t'($urandom);
            y[POSIT_W-1] = x[POSIT_W-1];
            issue(x, y);
        end
        close_test("equal signs");

        for (int n = 0; n < N_OPP; n++)
        begin
            x = posit_t'($urandom);
            y = -(x + posit_t'($urandom_range(64)) - posit_t'(32));
            issue(x, y);
        end
        close_test("opposite signs, close scales");

        for (int n = 0; n < N_WIDE; n++)
        begin
            x = {1'($urandom), 2'b11, 13'($urandom)};
            y = {1'($urandom), 3'b000, 12'($urandom)};
            issue(x, y);
        end
        close_test("separated scales");

        for (int n = 0; n < N_BURST; n++)
            issue(posit_t'($urandom), posit_t'($urandom));
        for (int n = 0; n < N_GAPPED; n++)
        begin
            idle($urandom_range(MAX_GAP));
            issue(posit_t'($urandom), posit_t'($urandom));
        end
        close_test("back to back and gapped");

        if (exp_q.size() != 0)
        begin
            $display("%0d expected results never arrived", exp_q.size());
            errors++;
        end
        $display("Summary: %0d results checked, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* vlog.f */
posit_fmt_pkg.sv
posit_raw_pkg.sv
posit_decode.sv
lead_one_count.sv
posit_raw_add.sv
posit_encode.sv
posit_add_unit.sv
posit_add_sva.sv
tb_posit_add.sv
